// ==== spio_uart_params.svh ====
// Serial port build parameters
`ifndef SPIO_UART_PARAMS_SVH
`define SPIO_UART_PARAMS_SVH

//////////////////////////////////////////////////
// Line levels
//////////////////////////////////////////////////

// Level driven during a start bit
`define START_BIT 1'b0

// Level of a stop bit and of the idle line
`define STOP_BIT 1'b1

//////////////////////////////////////////////////
// Baud rate
//////////////////////////////////////////////////

// Clocks per sub-sample pulse, eight pulses make one bit
`define UART_SUBSAMPLE_DIV 4

`endif

// ==== spio_uart_pkg.sv ====
// Serial port types
package spio_uart_pkg;

	// One data byte on the wire
	typedef logic [7:0] uart_byte_t;

	// Position within a bit time, counts 0 to 7
	typedef logic [2:0] subsample_cnt_t;

	// Baud divider count
	typedef logic [15:0] baud_div_t;

	// Receiver states
	// Data states and STOP are consecutive so the next state is value plus one
	typedef enum logic [3:0] {
		BIT0  = 4'd0,
		BIT1  = 4'd1,
		BIT2  = 4'd2,
		BIT3  = 4'd3,
		BIT4  = 4'd4,
		BIT5  = 4'd5,
		BIT6  = 4'd6,
		BIT7  = 4'd7,
		STOP  = 4'd8,
		IDLE  = 4'd9,
		START = 4'd10
	} rx_state_t;

	// Transmitter states
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_t;

endpackage

// ==== spio_uart_baud_gen.sv ====
// Sub-sample baud generator
`timescale 1ns/1ps

`include "spio_uart_params.svh"

module spio_uart_baud_gen
	import spio_uart_pkg::*;
#(
	// Clocks between sub-sample pulses, 1 or more
	parameter baud_div_t DIV = `UART_SUBSAMPLE_DIV
)
(
	input  logic CLK_IN,
	input  logic RESET_IN,
	// One-cycle pulse, eight per bit time
	output logic subsample_pulse_o
);

	// Reload value of the down counter
	localparam baud_div_t RELOAD = baud_div_t'(DIV - 16'd1);

	//////////////////////////////////////////////////
	// Divider
	//////////////////////////////////////////////////

	// Clocks left until the next pulse
	baud_div_t div_cnt;

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			div_cnt           <= RELOAD;
			subsample_pulse_o <= 1'b0;
		end
		else
		begin
			// Registered pulse lands one clock after the count hits zero
			subsample_pulse_o <= (div_cnt == '0);
			if (div_cnt == '0)
				div_cnt <= RELOAD;
			else
				div_cnt <= div_cnt - 16'd1;
		end
	end

endmodule

// ==== spio_uart_rx.sv ====
// Sub-sampling serial receiver
`timescale 1ns/1ps

`include "spio_uart_params.svh"

module spio_uart_rx
	import spio_uart_pkg::*;
(
	input  logic       CLK_IN,
	input  logic       RESET_IN,
	// Serial line, synchronized outside this block
	input  logic       rx_i,
	// Eight pulses per bit time from the baud generator
	input  logic       subsample_pulse_i,
	// Received byte, valid while vld_o is high
	output uart_byte_t data_o,
	// One-cycle strobe per received frame
	output logic       vld_o
);

	//////////////////////////////////////////////////
	// Sub-sample counter
	//////////////////////////////////////////////////

	// Free-running position within the bit time
	subsample_cnt_t counter;

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			counter <= '0;
		else if (subsample_pulse_i)
			counter <= counter + 3'd1;
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	rx_state_t state;

	// Counter value at the middle of each bit
	subsample_cnt_t bit_time;

	// High on the pulse where the line should be sampled
	logic sample_now;

	assign sample_now = subsample_pulse_i && (counter == bit_time);

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			state    <= IDLE;
			bit_time <= '0;
		end
		else if (subsample_pulse_i)
		begin
			case (state)
				IDLE:
				begin
					// Start edge seen
					// Bit centre sits half a bit later
					if (rx_i == `START_BIT)
					begin
						state    <= START;
						bit_time <= counter + 3'd4;
					end
				end

				START:
				begin
					// Line went back high early so treat it as a glitch
					if (rx_i != `START_BIT)
						state <= IDLE;
					else if (sample_now)
						state <= BIT0;
				end

				BIT0, BIT1, BIT2, BIT3, BIT4, BIT5, BIT6, BIT7:
				begin
					// Step through data bits and on to STOP after BIT7
					if (sample_now)
						state <= rx_state_t'(state + 4'd1);
				end

				STOP:
				begin
					// Stop level not checked
					if (sample_now)
						state <= IDLE;
				end

				default:
					state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////

	// Data enters at the MSB end so bit 0 ends up at the LSB
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			data_o <= '0;
		else if (sample_now)
		begin
			case (state)
				BIT0, BIT1, BIT2, BIT3, BIT4, BIT5, BIT6, BIT7:
					data_o <= {rx_i, data_o[7:1]};
				default:
					data_o <= data_o;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Output strobe
	//////////////////////////////////////////////////

	// Byte is complete by the middle of the stop bit
	assign vld_o = (state == STOP) && sample_now;

endmodule

// ==== spio_uart_tx.sv ====
// Serial frame transmitter
`timescale 1ns/1ps

`include "spio_uart_params.svh"

module spio_uart_tx
	import spio_uart_pkg::*;
(
	input  logic       CLK_IN,
	input  logic       RESET_IN,
	// Eight pulses per bit time from the baud generator
	input  logic       subsample_pulse_i,
	// Byte to send and its strobe
	input  uart_byte_t data_i,
	input  logic       vld_i,
	// High while a frame is pending or on the line
	output logic       busy_o,
	// Serial line
	output logic       tx_o
);

	tx_state_t state;

	// Pulses spent in the current bit
	subsample_cnt_t sub_cnt;

	// Data bit currently on the line
	logic [2:0] data_idx;

	// Remaining data bits, LSB goes out next
	uart_byte_t shift_reg;

	// Byte taken only when idle
	logic accept;

	// Last pulse of the current bit
	logic bit_end;

	assign accept  = vld_i && !busy_o;
	assign bit_end = subsample_pulse_i && (sub_cnt == 3'd7);

	//////////////////////////////////////////////////
	// Data shift register
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_IN)
	begin
		if (accept)
			shift_reg <= data_i;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			shift_reg <= {1'b1, shift_reg[7:1]};
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			state    <= TX_IDLE;
			busy_o   <= 1'b0;
			tx_o     <= `STOP_BIT;
			sub_cnt  <= '0;
			data_idx <= '0;
		end
		else
		begin
			if (accept)
				busy_o <= 1'b1;

			// Count pulses within a bit, wrapping after eight
			if (subsample_pulse_i)
				sub_cnt <= sub_cnt + 3'd1;

			case (state)
				TX_IDLE:
				begin
					// Pending byte starts on the next pulse
					if (busy_o && subsample_pulse_i)
					begin
						state   <= TX_START;
						tx_o    <= `START_BIT;
						sub_cnt <= '0;
					end
				end

				TX_START:
				begin
					if (bit_end)
					begin
						state    <= TX_DATA;
						tx_o     <= shift_reg[0];
						data_idx <= '0;
					end
				end

				TX_DATA:
				begin
					if (bit_end)
					begin
						if (data_idx == 3'd7)
						begin
							state <= TX_STOP;
							tx_o  <= `STOP_BIT;
						end
						else
						begin
							tx_o     <= shift_reg[0];
							data_idx <= data_idx + 3'd1;
						end
					end
				end

				TX_STOP:
				begin
					// Line already idle level, just release busy
					if (bit_end)
					begin
						state  <= TX_IDLE;
						busy_o <= 1'b0;
					end
				end

				default:
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== spio_uart.sv ====
// Serial port top level
`timescale 1ns/1ps

`include "spio_uart_params.svh"

module spio_uart
	import spio_uart_pkg::*;
(
	input  logic       CLK_IN,
	input  logic       RESET_IN,
	// Asynchronous serial input
	input  logic       rx_i,
	// Serial output
	output logic       tx_o,
	// Transmit byte, strobe and busy level
	input  uart_byte_t tx_data_i,
	input  logic       tx_vld_i,
	output logic       tx_busy_o,
	// Received byte and its valid pulse
	output uart_byte_t rx_data_o,
	output logic       rx_vld_o
);

	//////////////////////////////////////////////////
	// Input synchronizer
	//////////////////////////////////////////////////

	logic rx_meta;
	logic rx_sync;

	// Two flops, idle line level out of reset
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			rx_meta <= `STOP_BIT;
			rx_sync <= `STOP_BIT;
		end
		else
		begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////////////////////////
	// Baud generator, receiver and transmitter
	//////////////////////////////////////////////////

	// Shared by both directions
	logic subsample_pulse;

	spio_uart_baud_gen #(
		.DIV (baud_div_t'(`UART_SUBSAMPLE_DIV))
	) baud_gen_i (
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.subsample_pulse_o (subsample_pulse)
	);

	spio_uart_rx rx_i0 (
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.rx_i              (rx_sync),
		.subsample_pulse_i (subsample_pulse),
		.data_o            (rx_data_o),
		.vld_o             (rx_vld_o)
	);

	spio_uart_tx tx_i0 (
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.subsample_pulse_i (subsample_pulse),
		.data_i            (tx_data_i),
		.vld_i             (tx_vld_i),
		.busy_o            (tx_busy_o),
		.tx_o              (tx_o)
	);

endmodule

// ==== spio_uart_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module spio_uart_clk_gen
#(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
)
(
	output logic clk_o,
	output logic reset_o
);

	// Free-running clock, low at time zero
	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset high for the first cycles, released on a falling edge
	initial
	begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// ==== spio_uart_chk.sv ====
// Serial port protocol checks
`timescale 1ns/1ps

module spio_uart_chk
(
	input logic CLK_IN,
	input logic RESET_IN,
	input logic rx_vld_i,
	input logic tx_line_i,
	input logic tx_busy_i,
	input logic tx_vld_i
);

	//////////////////////////////////////////////////
	// Receiver
	//////////////////////////////////////////////////

	// Valid strobe lasts a single clock
	rx_vld_single: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		rx_vld_i |=> !rx_vld_i)
	else
		$error("rx_vld_o stayed high for two cycles");

	//////////////////////////////////////////////////
	// Transmitter
	//////////////////////////////////////////////////

	// Idle line sits at the stop level
	tx_idle_high: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		!tx_busy_i |-> tx_line_i)
	else
		$error("tx_o low while tx_busy_o is low");

	// Busy only follows an accepted strobe
	tx_busy_cause: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		$rose(tx_busy_i) |-> $past(tx_vld_i))
	else
		$error("tx_busy_o rose without tx_vld_i in the cycle before");

endmodule

bind spio_uart spio_uart_chk chk_i (
	.CLK_IN    (CLK_IN),
	.RESET_IN  (RESET_IN),
	.rx_vld_i  (rx_vld_o),
	.tx_line_i (tx_o),
	.tx_busy_i (tx_busy_o),
	.tx_vld_i  (tx_vld_i)
);

// ==== spio_uart_tb.sv ====
// Serial port testbench
`timescale 1ns/1ps

`include "spio_uart_params.svh"

module spio_uart_tb
	import spio_uart_pkg::*;
();

	// One bit on the line in clocks
	localparam int BIT_CLKS   = 8 * `UART_SUBSAMPLE_DIV;
	localparam int PERIOD_NS  = 40;
	// Frames sent plus idle gaps counted as whole frames
	localparam int NUM_FRAMES = 20;
	localparam int TIMEOUT_NS = NUM_FRAMES * 10 * BIT_CLKS * PERIOD_NS * 2;

	logic       CLK_IN;
	logic       RESET_IN;
	logic       rx_line;
	logic       loopback_sel;
	logic       rx_in;
	logic       tx_line;
	logic       tx_vld;
	logic       tx_busy;
	logic       rx_vld;
	uart_byte_t tx_data;
	uart_byte_t rx_data;

	int         errors;
	int         seed;
	uart_byte_t rx_q[$];

	spio_uart_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) clk_gen_i (
		.clk_o   (CLK_IN),
		.reset_o (RESET_IN)
	);

	// Loopback or testbench-driven line into the receiver
	assign rx_in = loopback_sel ? tx_line : rx_line;

	spio_uart uut (
		.CLK_IN    (CLK_IN),
		.RESET_IN  (RESET_IN),
		.rx_i      (rx_in),
		.tx_o      (tx_line),
		.tx_data_i (tx_data),
		.tx_vld_i  (tx_vld),
		.tx_busy_o (tx_busy),
		.rx_data_o (rx_data),
		.rx_vld_o  (rx_vld)
	);

	// Every valid strobe lands in the queue
	always @(negedge CLK_IN)
	begin
		if (rx_vld)
			rx_q.push_back(rx_data);
	end

	//////////////////////////////////////////////////
	// Compare and wait helpers
	//////////////////////////////////////////////////

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string msg);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s: got %02h, expected %02h", $time, msg, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s: got %b, expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic wait_rx(input int max_clks);
		int n;
		n = 0;
		while (rx_q.size() == 0 && n < max_clks)
		begin
			@(negedge CLK_IN);
			n++;
		end
		if (rx_q.size() == 0)
			report_error("no receive strobe came before the wait ran out");
	endtask

	task automatic wait_tx_idle(input int max_clks);
		int n;
		n = 0;
		while (tx_busy && n < max_clks)
		begin
			@(negedge CLK_IN);
			n++;
		end
		if (tx_busy)
			report_error("transmitter stayed busy longer than one frame");
	endtask

	// Exactly one byte expected in the queue
	task automatic expect_one_byte(input uart_byte_t exp, input string msg);
		if (rx_q.size() != 1)
			report_error($sformatf("%s: expected one strobe, saw %0d", msg, rx_q.size()));
		else
			check_byte(rx_q[0], exp, msg);
		rx_q.delete();
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic send_byte(input uart_byte_t b);
		@(negedge CLK_IN);
		tx_data = b;
		tx_vld  = 1'b1;
		@(negedge CLK_IN);
		tx_vld  = 1'b0;
	endtask

	// Start bit then eight data bits LSB first and a stop bit
	task automatic bang_frame(input uart_byte_t b);
		uart_byte_t bits;
		bits = b;
		rx_line = `START_BIT;
		repeat (BIT_CLKS) @(negedge CLK_IN);
		for (int i = 0; i < 8; i++)
		begin
			rx_line = bits[0];
			bits    = bits >> 1;
			repeat (BIT_CLKS) @(negedge CLK_IN);
		end
		rx_line = `STOP_BIT;
		repeat (BIT_CLKS) @(negedge CLK_IN);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic idle_after_reset();
		repeat (4 * BIT_CLKS)
		begin
			@(negedge CLK_IN);
			check_bit(tx_line, 1'b1, "tx_o idle after reset");
			check_bit(tx_busy, 1'b0, "tx_busy_o idle after reset");
			check_bit(rx_vld, 1'b0, "rx_vld_o idle after reset");
		end
	endtask

	task automatic frame_shape(input uart_byte_t b);
		uart_byte_t bits;
		int n;
		bits = b;
		n = 0;
		loopback_sel = 1'b0;
		send_byte(b);
		while (tx_line && n < 2 * BIT_CLKS)
		begin
			@(negedge CLK_IN);
			n++;
		end
		if (tx_line)
			report_error("tx_o never dropped for a start bit");
		// Middle of the start bit and then one sample per bit
		repeat (BIT_CLKS / 2) @(negedge CLK_IN);
		check_bit(tx_line, `START_BIT, "start bit");
		for (int i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge CLK_IN);
			check_bit(tx_line, bits[0], $sformatf("data bit %0d", i));
			bits = bits >> 1;
		end
		repeat (BIT_CLKS) @(negedge CLK_IN);
		check_bit(tx_line, `STOP_BIT, "stop bit");
		repeat (BIT_CLKS / 2 + 1) @(negedge CLK_IN);
		check_bit(tx_busy, 1'b0, "busy after stop bit");
		rx_q.delete();
	endtask

	task automatic direct_receive(input uart_byte_t b);
		loopback_sel = 1'b0;
		rx_q.delete();
		bang_frame(b);
		repeat (BIT_CLKS) @(negedge CLK_IN);
		expect_one_byte(b, $sformatf("direct receive of %02h", b));
	endtask

	task automatic glitch_rejection();
		loopback_sel = 1'b0;
		rx_q.delete();
		// Low for a quarter bit only
		rx_line = `START_BIT;
		repeat (8) @(negedge CLK_IN);
		rx_line = `STOP_BIT;
		repeat (12 * BIT_CLKS) @(negedge CLK_IN);
		if (rx_q.size() != 0)
			report_error("short low pulse produced a receive strobe");
		rx_q.delete();
		bang_frame(8'h3C);
		repeat (BIT_CLKS) @(negedge CLK_IN);
		expect_one_byte(8'h3C, "frame after glitch");
	endtask

	task automatic random_loopback();
		int rnd;
		uart_byte_t b;
		loopback_sel = 1'b1;
		rx_q.delete();
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			b   = rnd[7:0];
			send_byte(b);
			wait_rx(12 * BIT_CLKS);
			if (rx_q.size() > 0)
				check_byte(rx_q.pop_front(), b, $sformatf("loopback byte %0d", i));
			wait_tx_idle(4 * BIT_CLKS);
		end
	endtask

	task automatic strobe_while_busy();
		loopback_sel = 1'b1;
		rx_q.delete();
		send_byte(8'hC3);
		repeat (3 * BIT_CLKS) @(negedge CLK_IN);
		check_bit(tx_busy, 1'b1, "busy during frame");
		// Second strobe lands mid-frame
		send_byte(8'h18);
		wait_tx_idle(8 * BIT_CLKS);
		repeat (12 * BIT_CLKS) @(negedge CLK_IN);
		check_bit(tx_busy, 1'b0, "busy after single frame");
		check_bit(tx_line, `STOP_BIT, "line idle after single frame");
		expect_one_byte(8'hC3, "byte sent before busy strobe");
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		rx_line      = `STOP_BIT;
		loopback_sel = 1'b0;
		tx_data      = '0;
		tx_vld       = 1'b0;
		errors       = 0;
		seed         = 7001;
		wait (RESET_IN == 1'b0);
		@(negedge CLK_IN);
		idle_after_reset();
		frame_shape(8'h96);
		direct_receive(8'h00);
		direct_receive(8'hFF);
		direct_receive(8'hA5);
		direct_receive(8'h5A);
		glitch_rejection();
		random_loopback();
		strobe_while_busy();
		$display("Tests done, %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Run timed out after %0d ns before the tests finished", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
spio_uart_pkg.sv
spio_uart_baud_gen.sv
spio_uart_rx.sv
spio_uart_tx.sv
spio_uart.sv
spio_uart_clk_gen.sv
spio_uart_chk.sv
spio_uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the serial port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module spio_uart_tb -o spio_uart_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/spio_uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

echo "No failure found in $LOG"
exit 0
